//--- heapMemory.f
+incdir+verilog
+incdir+tests
verilog/heapOpsPkg.sv
verilog/heapStorePkg.sv
verilog/arrayAllocator.sv
verilog/sizeTable.sv
verilog/elementStore.sv
verilog/heapController.sv
verilog/heapMemory.sv
tests/heapMemoryTb.sv

//--- run.sh
#!/bin/sh
# Builds the heap memory testbench with Verilator, runs it and checks the log
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert \
  --top-module heapMemoryTb \
  -f heapMemory.f \
  -o heapMemorySim

./obj_dir/heapMemorySim > sim.log 2>&1
cat sim.log

if grep -q "Simulation failed" sim.log; then
  echo "Run reported a failure"
  exit 1
fi
echo "Run finished without failures"

//--- tests/heapModel.svh
// Reference model of the heap
// Allocation state, sizes, element data and the expected out of each request

`ifndef HEAP_MODEL_SVH
`define HEAP_MODEL_SVH

bit         modelAllocated [`HEAP_ARRAYS];                 // Nothing allocated at start
int         modelSize [`HEAP_ARRAYS];
heapElement modelData [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];  // Survives free and Reset action
bit         modelWritten [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH]; // Slot holds a known value
int         modelFresh;                                    // First handle never issued
int         modelFreed [$];                                // Freed handles, newest last
heapElement modelOut = '0;                                 // Out is zero after reset
bit         modelOutKnown = 1'b1;

// Handle that the next Alloc hands out
function automatic int nextFreeHandle();
  if (modelFreed.size() != 0) begin
    return modelFreed[$];
  end
  return modelFresh;
endfunction

function automatic void recordOut(heapElement value, bit known);
  modelOut      = value;
  modelOutKnown = known;
endfunction

//----------------------------------------------------------------------------
// One sampled request, returns the error the DUT has to report
//----------------------------------------------------------------------------
function automatic heapError applyRequest(heapAction act, int h, int i, heapElement d);
  bit         rmw;
  heapElement old;
  heapElement updated;
  heapError   err;
  rmw = act inside {opAdd, opAddAfter, opSubtract, opSubAfter, opAnd, opOr, opXor};
  if (!rmw && !(act inside {opReset, opWrite, opRead, opSize, opPush, opPop, opAlloc, opFree}))
    err = badAction;
  else if (!(act inside {opReset, opAlloc}) && !modelAllocated[h])
    err = notAllocated;
  else if ((rmw || act == opRead) && i >= modelSize[h])
    err = outOfBounds;
  else if (act == opPush && modelSize[h] == `HEAP_ARRAY_LENGTH)
    err = arrayFull;
  else if (act == opPop && modelSize[h] == 0)
    err = arrayEmpty;
  else if (act == opAlloc && modelFreed.size() == 0 && modelFresh == `HEAP_ARRAYS)
    err = noSpace;
  else
    err = none;
  if (err != none) begin
    return err;                                            // State and out stay as they are
  end
  case (act)
    opReset: begin
      foreach (modelAllocated[n]) begin
        modelAllocated[n] = 1'b0;
      end
      modelFresh = 0;
      modelFreed.delete();
    end
    opAlloc: begin
      h = nextFreeHandle();
      if (modelFreed.size() != 0) begin
        void'(modelFreed.pop_back());                      // Newest freed handle first
      end else begin
        modelFresh++;
      end
      modelAllocated[h] = 1'b1;
      modelSize[h]      = 0;
      recordOut(heapElement'(h), 1'b1);
    end
    opFree: begin
      modelAllocated[h] = 1'b0;
      modelFreed.push_back(h);
    end
    opWrite: begin
      modelData[h][i]    = d;
      modelWritten[h][i] = 1'b1;
      if (i >= modelSize[h]) begin
        modelSize[h] = i + 1;                              // Grows to cover the index
      end
      recordOut(d, 1'b1);
    end
    opRead: recordOut(modelData[h][i], modelWritten[h][i]);
    opSize: recordOut(heapElement'(modelSize[h]), 1'b1);
    opPush: begin
      modelData[h][modelSize[h]]    = d;
      modelWritten[h][modelSize[h]] = 1'b1;
      modelSize[h]++;
    end
    opPop: begin
      modelSize[h]--;
      recordOut(modelData[h][modelSize[h]], modelWritten[h][modelSize[h]]);
    end
    default: begin
      old = modelData[h][i];
      case (act)
        opAdd, opAddAfter:      updated = old + d;         // Wraps at data width
        opSubtract, opSubAfter: updated = old - d;
        opAnd:                  updated = old & d;
        opOr:                   updated = old | d;
        default:                updated = old ^ d;
      endcase
      modelData[h][i] = updated;
      recordOut((act inside {opAddAfter, opSubAfter}) ? old : updated, modelWritten[h][i]);
    end
  endcase
  return none;
endfunction

`endif

//--- tests/heapMemoryTb.sv
// Heap memory testbench
// Request sequences, model checks by concurrent assertions, timeout and report

`timescale 1ns/1ps

`include "heap_consts.svh"

module heapMemoryTb;
  import heapOpsPkg::*;
  import heapStorePkg::*;

  localparam int driveDelay  = 2;                          // ns after the rising edge
  localparam int resetCycles = 10;
  localparam int testCycles  = 15 + 28 + 12 + 19 + 13 + 4; // Requests of the six tests
  localparam int cycleLimit  = 4 * (resetCycles + testCycles + 4);

  logic       clock = 1'b0;
  logic       reset;
  logic       request;
  heapAction  action;
  heapHandle  array;
  heapIndex   index;
  heapElement in;
  heapElement out;
  heapError   error;
  logic       done;

  heapError   expectedError;
  heapElement expectedOut;
  logic       expectedKnown;                               // Out built from written data only
  int         valueErrors    = 0;
  int         protocolErrors = 0;
  int         cycleCount     = 0;
  heapAction  rmwOps [7]       = '{opAdd, opAddAfter, opSubtract, opSubAfter, opAnd, opOr, opXor};
  heapAction  strayOps [7]     = '{opWrite, opRead, opSize, opPush, opPop, opFree, opAdd};
  logic [7:0] unknownCodes [4] = '{8'd0, 8'd5, 8'd99, 8'd255};

  `include "heapModel.svh"

  heapMemory dut_i (.*);

  always #20 clock = ~clock;                               // 40 ns period

  // Model follows every sampled request
  always @(posedge clock) begin
    heapError e;
    if (reset && request) begin
      e = applyRequest(action, int'(array), int'(index), in);
      expectedError <= e;
      expectedOut   <= modelOut;
      expectedKnown <= modelOutKnown;
    end
  end

  always @(posedge clock) begin
    cycleCount++;
    if (cycleCount >= cycleLimit) begin
      $display("Timeout after %0d cycles, the request sequence did not finish", cycleCount);
      $display("Simulation failed");
      $finish;
    end
  end

  //--------------------------------------------------------------------------
  // Checks
  //--------------------------------------------------------------------------
  doneAfterRequest : assert property (@(posedge clock) disable iff (!reset)
    request |=> done)
    else begin
      protocolErrors++;
      $display("No done pulse one cycle after a request, seen at %0t", $time);
    end

  quietWithoutRequest : assert property (@(posedge clock) disable iff (!reset)
    !request |=> !done)
    else begin
      protocolErrors++;
      $display("Done pulse without a request, seen at %0t", $time);
    end

  errorMatchesModel : assert property (@(posedge clock) disable iff (!reset)
    done |-> error == expectedError)
    else begin
      valueErrors++;
      $display("Error at %0t: error expected %0d, actual %0d", $time,
               $sampled(expectedError), $sampled(error));
    end

  outMatchesModel : assert property (@(posedge clock) disable iff (!reset)
    done && expectedKnown |-> out == expectedOut)
    else begin
      valueErrors++;
      $display("Error at %0t: out expected %0h, actual %0h", $time,
               $sampled(expectedOut), $sampled(out));
    end

  task automatic sendRequest(heapAction act, int handle, int slot, heapElement data);
    @(posedge clock);
    #driveDelay;
    request = 1'b1;
    action  = act;
    array   = heapHandle'(handle);
    index   = heapIndex'(slot);
    in      = data;
  endtask

  function automatic heapElement randomElement();
    return heapElement'($urandom);
  endfunction

  //--------------------------------------------------------------------------
  // Stimulus
  //--------------------------------------------------------------------------
  initial begin
    int h;
    int k;
    void'($urandom(32'hc27df60f));                         // One seed for the whole run
    reset   = 1'b0;
    request = 1'b0;
    action  = opRead;
    array   = '0;
    index   = '0;
    in      = '0;
    repeat (resetCycles) @(posedge clock);
    #driveDelay;
    reset = 1'b1;

    // Fill the heap, then LIFO reuse and a double free
    for (int n = 0; n <= `HEAP_ARRAYS; n++) begin
      sendRequest(opAlloc, 0, 0, '0);                      // Last one finds no space
    end
    sendRequest(opFree, 2, 0, '0);
    sendRequest(opFree, 5, 0, '0);
    sendRequest(opAlloc, 0, 0, '0);                        // Gets 5 back first
    sendRequest(opAlloc, 0, 0, '0);
    sendRequest(opFree, 3, 0, '0);
    sendRequest(opFree, 3, 0, '0);

    // Write, read and size, starting from an empty heap
    sendRequest(opReset, 0, 0, '0);
    sendRequest(opAlloc, 0, 0, '0);                        // Handle 0
    for (int n = 0; n < `HEAP_ARRAY_LENGTH; n++) begin
      sendRequest(opWrite, 0, n, randomElement());
    end
    repeat (8) begin
      k = $urandom % `HEAP_ARRAY_LENGTH;
      sendRequest(opWrite, 0, k, randomElement());
      sendRequest(opRead, 0, k, '0);
    end
    sendRequest(opSize, 0, 0, '0);
    sendRequest(opAlloc, 0, 0, '0);                        // Handle 1
    k = $urandom % (`HEAP_ARRAY_LENGTH - 1);
    sendRequest(opWrite, 1, k, randomElement());
    sendRequest(opSize, 1, 0, '0);
    sendRequest(opRead, 1, k + 1, '0);                     // At the size
    sendRequest(opRead, 1, `HEAP_ARRAY_LENGTH - 1, '0);

    // Push until full, pop until empty
    h = nextFreeHandle();
    sendRequest(opAlloc, 0, 0, '0);
    repeat (`HEAP_ARRAY_LENGTH + 1) sendRequest(opPush, h, 0, randomElement());
    sendRequest(opSize, h, 0, '0);
    repeat (`HEAP_ARRAY_LENGTH + 1) sendRequest(opPop, h, 0, '0);

    // Read-modify-write on a filled array
    h = nextFreeHandle();
    sendRequest(opAlloc, 0, 0, '0);
    for (int n = 0; n < `HEAP_ARRAY_LENGTH; n++) begin
      sendRequest(opWrite, h, n, randomElement());
    end
    foreach (rmwOps[n]) begin
      k = $urandom % `HEAP_ARRAY_LENGTH;
      sendRequest(rmwOps[n], h, k, randomElement());
      sendRequest(opRead, h, k, '0);                       // Shows the stored result
    end

    // Never allocated handle and unknown opcodes
    foreach (strayOps[n]) begin
      sendRequest(strayOps[n], `HEAP_ARRAYS - 1, 0, randomElement());
    end
    foreach (unknownCodes[n]) begin
      sendRequest(heapAction'(unknownCodes[n]), h, 0, randomElement());
    end
    sendRequest(opRead, h, $urandom % `HEAP_ARRAY_LENGTH, '0);
    sendRequest(opSize, h, 0, '0);

    // Reset action frees every array
    sendRequest(opReset, 0, 0, '0);
    sendRequest(opRead, h, 0, '0);
    sendRequest(opAlloc, 0, 0, '0);
    sendRequest(opSize, 0, 0, '0);

    @(posedge clock);
    #driveDelay;
    request = 1'b0;
    repeat (3) @(posedge clock);                           // Last checks settle
    $display("Value errors: %0d, protocol errors: %0d", valueErrors, protocolErrors);
    if (valueErrors + protocolErrors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

//--- verilog/heapMemory.sv
// Heap memory top level
// Controller, allocator, size table and element store wired together

`timescale 1ns/1ps

module heapMemory (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     request,               // One request per clock
  input  heapOpsPkg::heapAction    action,
  input  heapStorePkg::heapHandle  array,
  input  heapStorePkg::heapIndex   index,
  input  heapStorePkg::heapElement in,
  output heapStorePkg::heapElement out,
  output heapOpsPkg::heapError     error,
  output logic                     done
);
  import heapStorePkg::*;

  logic       clearAll;
  logic       allocate;
  logic       releaseHandle;
  logic       allocated;
  logic       canAllocate;
  logic       setSize;
  logic       writeElement;
  heapHandle  nextHandle;
  heapHandle  sizeArray;
  heapSize    currentSize;
  heapSize    newSize;
  heapIndex   readIndex;
  heapIndex   writeIndex;
  heapElement element;
  heapElement writeData;

  heapController controller_i (
    .clock         (clock),
    .reset         (reset),
    .request       (request),
    .action        (action),
    .array         (array),
    .index         (index),
    .in            (in),
    .allocated     (allocated),
    .canAllocate   (canAllocate),
    .nextHandle    (nextHandle),
    .currentSize   (currentSize),
    .element       (element),
    .clearAll      (clearAll),
    .allocate      (allocate),
    .releaseHandle (releaseHandle),
    .setSize       (setSize),
    .writeElement  (writeElement),
    .sizeArray     (sizeArray),
    .newSize       (newSize),
    .readIndex     (readIndex),
    .writeIndex    (writeIndex),
    .writeData     (writeData),
    .out           (out),
    .error         (error),
    .done          (done)
  );

  arrayAllocator allocator_i (
    .clock         (clock),
    .reset         (reset),
    .clearAll      (clearAll),
    .allocate      (allocate),
    .releaseHandle (releaseHandle),
    .array         (array),
    .allocated     (allocated),
    .canAllocate   (canAllocate),
    .nextHandle    (nextHandle)
  );

  sizeTable sizes_i (
    .clock       (clock),
    .reset       (reset),
    .array       (sizeArray),                             // New handle on alloc
    .setSize     (setSize),
    .newSize     (newSize),
    .currentSize (currentSize)
  );

  elementStore store_i (
    .clock        (clock),
    .array        (array),
    .index        (readIndex),                            // Last slot on pop
    .writeElement (writeElement),
    .writeIndex   (writeIndex),
    .writeData    (writeData),
    .element      (element)
  );

endmodule

//--- verilog/heapController.sv
// Heap controller
// Opcode decode, request checks, RMW arithmetic, storage strobes
// and the registered out, error and done

`timescale 1ns/1ps

`include "heap_consts.svh"

module heapController (
  input  logic                     clock,
  input  logic                     reset,
  input  logic                     request,
  input  heapOpsPkg::heapAction    action,
  input  heapStorePkg::heapHandle  array,
  input  heapStorePkg::heapIndex   index,
  input  heapStorePkg::heapElement in,
  input  logic                     allocated,             // From allocator
  input  logic                     canAllocate,
  input  heapStorePkg::heapHandle  nextHandle,
  input  heapStorePkg::heapSize    currentSize,           // From size table
  input  heapStorePkg::heapElement element,               // From element store
  output logic                     clearAll,
  output logic                     allocate,
  output logic                     releaseHandle,
  output logic                     setSize,
  output logic                     writeElement,
  output heapStorePkg::heapHandle  sizeArray,             // Size table address
  output heapStorePkg::heapSize    newSize,
  output heapStorePkg::heapIndex   readIndex,
  output heapStorePkg::heapIndex   writeIndex,
  output heapStorePkg::heapElement writeData,
  output heapStorePkg::heapElement out,
  output heapOpsPkg::heapError     error,
  output logic                     done
);
  import heapOpsPkg::*;
  import heapStorePkg::*;

  logic       knownAction;                                // Opcode is supported
  logic       needsIndex;                                 // Read and RMW ops
  logic       accept;                                     // Request passes checks
  heapSize    wideIndex;
  heapError   checkError;
  heapElement aluValue;                                   // Value to store
  heapElement result;                                     // Value for out

  assign wideIndex = heapSize'(index);
  assign sizeArray = (action == opAlloc) ? nextHandle : array;   // Zero new size
  assign readIndex = (action == opPop) ? heapIndex'(currentSize - 1'b1) : index;
  assign writeIndex = (action == opPush) ? heapIndex'(currentSize) : index;

  //--------------------------------------------------------------------------
  // Request checks, first failure wins
  //--------------------------------------------------------------------------
  always_comb begin
    knownAction = 1'b1;
    needsIndex  = 1'b0;
    case (action)
      opReset, opWrite, opSize, opPush, opPop, opAlloc, opFree: ;
      opRead, opAdd, opAddAfter, opSubtract, opSubAfter, opOr, opXor, opAnd:
        needsIndex = 1'b1;
      default: knownAction = 1'b0;
    endcase

    if (!knownAction) begin
      checkError = badAction;
    end else if (action != opReset && action != opAlloc && !allocated) begin
      checkError = notAllocated;
    end else if (needsIndex && wideIndex >= currentSize) begin
      checkError = outOfBounds;
    end else if (action == opPush && currentSize == `HEAP_ARRAY_LENGTH) begin
      checkError = arrayFull;
    end else if (action == opPop && currentSize == '0) begin
      checkError = arrayEmpty;
    end else if (action == opAlloc && !canAllocate) begin
      checkError = noSpace;
    end else begin
      checkError = none;
    end
  end

  assign accept = request && (checkError == none);

  //--------------------------------------------------------------------------
  // Arithmetic and logic for read-modify-write
  //--------------------------------------------------------------------------
  always_comb begin
    case (action)
      opAdd, opAddAfter:      aluValue = element + in;    // Wraps at data width
      opSubtract, opSubAfter: aluValue = element - in;
      opAnd:                  aluValue = element & in;
      opOr:                   aluValue = element | in;
      opXor:                  aluValue = element ^ in;
      default:                aluValue = in;              // Write and push
    endcase
  end

  always_comb begin
    case (action)
      opAlloc: newSize = '0;                              // Fresh array empty
      opPush:  newSize = currentSize + 1'b1;
      opPop:   newSize = currentSize - 1'b1;
      default: newSize = wideIndex + 1'b1;                // Write grows to index
    endcase
  end

  always_comb begin
    case (action)
      opRead, opPop, opAddAfter, opSubAfter: result = element;  // Old value
      opAdd, opSubtract, opAnd, opOr, opXor: result = aluValue; // New value
      opWrite: result = in;
      opAlloc: result = heapElement'(nextHandle);
      opSize:  result = heapElement'(currentSize);
      default: result = out;                              // Reset, free, push
    endcase
  end

  //--------------------------------------------------------------------------
  // Storage strobes
  //--------------------------------------------------------------------------
  assign clearAll      = accept && action == opReset;
  assign allocate      = accept && action == opAlloc;
  assign releaseHandle = accept && action == opFree;
  assign writeElement  = accept && (action == opWrite || action == opPush ||
                                    (needsIndex && action != opRead));
  assign writeData     = aluValue;
  assign setSize       = accept && (action == opPush || action == opPop ||
                                    action == opAlloc ||
                                    (action == opWrite && wideIndex >= currentSize));

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      out   <= '0;
      error <= none;
      done  <= 1'b0;
    end else begin
      done <= request;                                    // One cycle later
      if (request) begin
        error <= checkError;
      end
      if (accept) begin
        out <= result;                                    // Errors keep old out
      end
    end
  end

endmodule

//--- verilog/elementStore.sv
// Element store
// Element memory of all arrays, written on the edge, read combinationally

`timescale 1ns/1ps

`include "heap_consts.svh"

module elementStore (
  input  logic                     clock,
  input  heapStorePkg::heapHandle  array,
  input  heapStorePkg::heapIndex   index,                 // Read position
  input  logic                     writeElement,
  input  heapStorePkg::heapIndex   writeIndex,            // Push writes at size
  input  heapStorePkg::heapElement writeData,
  output heapStorePkg::heapElement element
);
  import heapStorePkg::*;

  heapElement memory [`HEAP_ARRAYS][`HEAP_ARRAY_LENGTH];  // Fixed block per array

  assign element = memory[array][index];                  // Old value for RMW

  always_ff @(posedge clock) begin
    if (writeElement) begin
      memory[array][writeIndex] <= writeData;
    end
  end

endmodule

//--- verilog/sizeTable.sv
// Size table
// Current element count of every array

`timescale 1ns/1ps

`include "heap_consts.svh"

module sizeTable (
  input  logic                    clock,
  input  logic                    reset,
  input  heapStorePkg::heapHandle array,                  // Array to read or set
  input  logic                    setSize,
  input  heapStorePkg::heapSize   newSize,
  output heapStorePkg::heapSize   currentSize
);
  import heapStorePkg::*;

  heapSize sizes [`HEAP_ARRAYS];                          // One size per array

  assign currentSize = sizes[array];

  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      for (int i = 0; i < `HEAP_ARRAYS; i++) begin
        sizes[i] <= '0;                                   // All arrays empty
      end
    end else if (setSize) begin
      sizes[array] <= newSize;                            // Write, push, pop, alloc
    end
  end

  // Controller never asks for a size beyond the array length
  sizeInRange : assert property (@(posedge clock) disable iff (!reset)
    setSize |-> newSize <= `HEAP_ARRAY_LENGTH);

endmodule

//--- verilog/arrayAllocator.sv
// Array allocator
// Allocation flags, fresh handle count and LIFO stack of freed handles

`timescale 1ns/1ps

`include "heap_consts.svh"

module arrayAllocator (
  input  logic                    clock,
  input  logic                    reset,
  input  logic                    clearAll,               // Reset action
  input  logic                    allocate,               // Take nextHandle
  input  logic                    releaseHandle,          // Return array
  input  heapStorePkg::heapHandle array,
  output logic                    allocated,              // Flag of array
  output logic                    canAllocate,
  output heapStorePkg::heapHandle nextHandle
);
  import heapStorePkg::*;

  logic [`HEAP_ARRAYS-1:0]     allocFlags;                // One flag per array
  logic [`HEAP_ADDRESS_BITS:0] issuedCount;               // Fresh handles handed out
  logic [`HEAP_ADDRESS_BITS:0] freeTop;                   // Entries on free stack
  heapHandle                   freeStack [`HEAP_ARRAYS];  // Freed handles
  heapHandle                   topSlot;                   // Newest stack entry

  assign topSlot     = heapHandle'(freeTop - 1'b1);
  assign allocated   = allocFlags[array];
  assign canAllocate = (freeTop != '0) || (issuedCount < `HEAP_ARRAYS);
  assign nextHandle  = (freeTop != '0) ? freeStack[topSlot]
                                       : heapHandle'(issuedCount); // Reuse first

  //--------------------------------------------------------------------------
  // Flags and counters
  //--------------------------------------------------------------------------
  always_ff @(posedge clock or negedge reset) begin
    if (!reset) begin
      allocFlags  <= '0;
      issuedCount <= '0;
      freeTop     <= '0;
    end else if (clearAll) begin                          // Forget all handles
      allocFlags  <= '0;
      issuedCount <= '0;
      freeTop     <= '0;
    end else if (allocate) begin
      allocFlags[nextHandle] <= 1'b1;
      if (freeTop != '0) begin
        freeTop <= freeTop - 1'b1;                        // Pop freed handle
      end else begin
        issuedCount <= issuedCount + 1'b1;                // Fresh handle
      end
    end else if (releaseHandle) begin
      allocFlags[array] <= 1'b0;
      freeTop           <= freeTop + 1'b1;
    end
  end

  // Freed handle stack, filled on release
  always_ff @(posedge clock) begin
    if (releaseHandle && !clearAll) begin
      freeStack[heapHandle'(freeTop)] <= array;           // Push freed handle
    end
  end

  noBlindAllocate : assert property (@(posedge clock) disable iff (!reset)
    allocate |-> canAllocate);

  noStaleRelease : assert property (@(posedge clock) disable iff (!reset)
    releaseHandle |-> allocated);

endmodule

//--- verilog/heapStorePkg.sv
// Storage side types
// Handle, index, size and element words

`include "heap_consts.svh"

package heapStorePkg;

  typedef logic [`HEAP_ADDRESS_BITS-1:0] heapHandle;      // Array number
  typedef logic [`HEAP_INDEX_BITS-1:0]   heapIndex;       // Element position
  typedef logic [`HEAP_INDEX_BITS:0]     heapSize;        // 0 up to full length
  typedef logic [`HEAP_DATA_BITS-1:0]    heapElement;     // Element payload

endpackage

//--- verilog/heapOpsPkg.sv
// Request side types
// Opcode and error code enumerations of the heap

package heapOpsPkg;

  //--------------------------------------------------------------------------
  // Opcodes, sparse numbering
  //--------------------------------------------------------------------------
  typedef enum logic [7:0] {
    opReset    = 8'd1,                                    // Free every array
    opWrite    = 8'd2,                                    // Store an element
    opRead     = 8'd3,                                    // Fetch an element
    opSize     = 8'd4,                                    // Report array size
    opPush     = 8'd14,                                   // Append at the end
    opPop      = 8'd15,                                   // Remove from the end
    opAlloc    = 8'd18,                                   // Claim a handle
    opFree     = 8'd19,                                   // Return a handle
    opAdd      = 8'd20,                                   // Add, new value out
    opAddAfter = 8'd21,                                   // Add, old value out
    opSubtract = 8'd22,                                   // Subtract, new value out
    opSubAfter = 8'd23,                                   // Subtract, old value out
    opOr       = 8'd28,
    opXor      = 8'd29,
    opAnd      = 8'd30
  } heapAction;

  //--------------------------------------------------------------------------
  // Error codes
  //--------------------------------------------------------------------------
  typedef enum logic [2:0] {
    none         = 3'd0,                                  // Request succeeded
    notAllocated = 3'd1,                                  // Handle not in use
    outOfBounds  = 3'd2,                                  // Index at or past size
    arrayFull    = 3'd3,                                  // Push with no room
    arrayEmpty   = 3'd4,                                  // Pop with nothing left
    noSpace      = 3'd5,                                  // No handle to allocate
    badAction    = 3'd6                                   // Unknown opcode
  } heapError;

endpackage

//--- verilog/heap_consts.svh
// Heap geometry macros
// Widths of handles, indices and elements, plus derived array counts

`ifndef HEAP_CONSTS_SVH
`define HEAP_CONSTS_SVH

`define HEAP_ADDRESS_BITS 3                               // Bits in an array handle
`define HEAP_INDEX_BITS   2                               // Bits in an element index
`define HEAP_DATA_BITS    12                              // Bits in one element

`define HEAP_ARRAYS       (1 << `HEAP_ADDRESS_BITS)      // Arrays in the heap
`define HEAP_ARRAY_LENGTH (1 << `HEAP_INDEX_BITS)        // Elements per array

`endif
